/* all.f */
+incdir+bench
logic/dist_pkg.sv
logic/dist_cfg_if.sv
logic/apb_ctrl.sv
logic/dest_sequencer.sv
logic/unicast_chain.sv
logic/delivery_counters.sv
logic/dist_fabric_top.sv
bench/tb_dist_fabric.sv

/* bench/tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

////////////////////////////////////////
// error bookkeeping
////////////////////////////////////////

// wrong values
int mismatch_errs = 0;
// missing or unexpected words, stuck drains
int other_errs    = 0;

task automatic compare(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual)
	begin
		mismatch_errs++;
		$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
	end
endtask

////////////////////////////////////////
// apb master
////////////////////////////////////////

// setup phase, then access phase, then idle
task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata);
	@(negedge clk);
	psel    = 1'b1;
	pwrite  = 1'b1;
	penable = 1'b0;
	paddr   = addr;
	pwdata  = wdata;
	@(negedge clk);
	penable = 1'b1;
	// write lands on the rising edge in between
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] rdata);
	@(negedge clk);
	psel    = 1'b1;
	pwrite  = 1'b0;
	penable = 1'b0;
	paddr   = addr;
	@(negedge clk);
	penable = 1'b1;
	// read data is combinational, sample mid access phase
	#(CLK_PERIOD / 4);
	rdata = prdata;
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic check_reg(input string name, input logic [ADDR_W-1:0] addr,
	input logic [31:0] expected);
	logic [31:0] rdata;
	apb_read(addr, rdata);
	compare(name, expected, rdata);
endtask

`endif

/* bench/tb_dist_fabric.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dist_fabric;
	import dist_pkg::*;

	localparam int CLK_PERIOD  = 40;
	// word counts per test
	localparam int N_SIDEBAND  = 300;
	localparam int N_RR_BURST  = 40;
	localparam int N_RR_BURSTS = 8;
	localparam int N_PARTIAL   = 100;
	localparam int N_DISABLE   = 60;
	localparam int TOTAL_WORDS = N_SIDEBAND + N_RR_BURST * N_RR_BURSTS
		+ 2 * N_PARTIAL + N_DISABLE;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 10;
	// full chain pass plus margin
	localparam int DRAIN_LIMIT = 4 * NUM_NODE + 8;
	// sequencer register and node register, hops add one each
	localparam int BASE_LAT = 2;

	logic                           clk = 1'b0;
	logic                           rst;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [ADDR_W-1:0]              paddr;
	logic [APB_DW-1:0]              pwdata;
	logic [APB_DW-1:0]              prdata;
	logic                           valid;
	logic [DATA_WIDTH-1:0]          data;
	logic [NODE_W-1:0]              dest;
	logic                           ready;
	logic [NUM_NODE-1:0]            node_valid;
	logic [NUM_NODE*DATA_WIDTH-1:0] node_data;

	integer seed;
	string  phase = "reset";
	// rising edge count
	int     cyc   = 0;

	// model copy of the register settings
	logic                  m_enable = 1'b0;
	logic                  m_mode   = MODE_SIDEBAND;
	logic [NUM_NODE-1:0]   m_mask   = '1;
	logic [NODE_W-1:0]     m_rr_ptr = '0;
	int                    m_deliv [NUM_NODE];
	int                    m_drops  = 0;
	// words owed to each node, with the edge they should show at
	logic [DATA_WIDTH-1:0] exp_data [NUM_NODE][$];
	int                    exp_edge [NUM_NODE][$];

	`include "tb_apb_tasks.svh"

	dist_fabric_top UUT (
		.clk          (clk),
		.i_rst        (rst),
		.i_psel       (psel),
		.i_penable    (penable),
		.i_pwrite     (pwrite),
		.i_paddr      (paddr),
		.i_pwdata     (pwdata),
		.o_prdata     (prdata),
		.i_valid      (valid),
		.i_data       (data),
		.i_dest       (dest),
		.o_ready      (ready),
		.o_node_valid (node_valid),
		.o_node_data  (node_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles in phase %s", WATCHDOG_CYCLES, phase);
		$display("Test FAILED");
		$finish;
	end

	function automatic int pending();
		int total;
		total = 0;
		for (int n = 0; n < NUM_NODE; n++)
			total += exp_data[n].size();
		return total;
	endfunction

	function automatic logic [31:0] ctrl_word(input logic en, input logic mode);
		return {30'b0, mode, en};
	endfunction

	// destination rule, round robin scans upward from the pointer
	function automatic void route_word(input logic [NODE_W-1:0] req,
		output logic [NODE_W-1:0] tag, output logic drop);
		int  idx;
		bit  found;
		found = 1'b0;
		tag   = req;
		if (m_mode == MODE_ROUND_ROBIN)
		begin
			for (int k = 0; k < NUM_NODE; k++)
			begin
				idx = (int'(m_rr_ptr) + k) % NUM_NODE;
				if (!found && m_mask[idx])
				begin
					found = 1'b1;
					tag   = NODE_W'(idx);
				end
			end
			drop = !found;
			// four nodes, so the pointer wraps on its own
			if (found)
				m_rr_ptr = tag + 1'b1;
		end
		else
			drop = !m_mask[req];
	endfunction

	// register write that the model follows
	task automatic config_write(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata);
		apb_write(addr, wdata);
		case (addr)
			ADDR_CTRL:
			begin
				m_enable = wdata[0];
				m_mode   = wdata[1];
			end
			ADDR_MASK:
				m_mask = wdata[NUM_NODE-1:0];
			ADDR_CLEAR:
			begin
				if (wdata[0])
				begin
					for (int n = 0; n < NUM_NODE; n++)
						m_deliv[n] = 0;
					m_drops = 0;
				end
			end
			default:
				;
		endcase
	endtask

	// random valid gaps, random payload and sideband tag
	task automatic drive_words(input int n_words);
		int sent;
		sent = 0;
		while (sent < n_words)
		begin
			@(negedge clk);
			valid = (($random(seed) & 3) != 0);
			data  = $random(seed);
			dest  = NODE_W'($random(seed));
			if (valid)
				sent++;
		end
		@(negedge clk);
		valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((pending() != 0) && (waited < DRAIN_LIMIT))
		begin
			@(negedge clk);
			waited++;
		end
		if (pending() != 0)
		begin
			other_errs++;
			$display("%s: %0d words never reached their node", phase, pending());
		end
		// let counters settle and stray words show up
		repeat (4) @(negedge clk);
	endtask

	task automatic check_counters(input string name);
		for (int n = 0; n < NUM_NODE; n++)
			check_reg($sformatf("%s node %0d count", name, n),
				ADDR_CNT_BASE + ADDR_W'(4 * n), 32'(m_deliv[n]));
		check_reg({name, " drop count"}, ADDR_DROP, 32'(m_drops));
	endtask

	////////////////////////////////////////
	// model and output checks
	////////////////////////////////////////

	always @(posedge clk)
	begin
		logic [NODE_W-1:0]     tag;
		logic                  drop;
		logic [DATA_WIDTH-1:0] got;
		if (!rst)
		begin
			// values from before this edge
			for (int n = 0; n < NUM_NODE; n++)
			begin
				if (node_valid[n])
				begin
					got = node_data[n*DATA_WIDTH +: DATA_WIDTH];
					if (exp_data[n].size() == 0)
					begin
						other_errs++;
						$display("%s: node %0d delivered %0h but no word was due", phase, n, got);
					end
					else
					begin
						compare($sformatf("%s node %0d data", phase, n),
							exp_data[n].pop_front(), got);
						compare($sformatf("%s node %0d arrival edge", phase, n),
							32'(exp_edge[n].pop_front()), 32'(cyc));
					end
				end
			end
			compare({phase, " ready"}, 32'(m_enable), 32'(ready));
			// acceptance
			if (valid && m_enable)
			begin
				route_word(dest, tag, drop);
				if (drop)
					m_drops++;
				else
				begin
					exp_data[tag].push_back(data);
					exp_edge[tag].push_back(cyc + BASE_LAT + int'(tag));
					m_deliv[tag]++;
				end
			end
		end
		cyc++;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		logic [NUM_NODE-1:0] mask;
		seed    = 32'h8b3d;
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		valid   = 1'b0;
		data    = '0;
		dest    = '0;
		for (int n = 0; n < NUM_NODE; n++)
			m_deliv[n] = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle state after reset
		compare("reset ready", 32'(1'b0), 32'(ready));
		compare("reset node valid", 32'(0), 32'(node_valid));
		check_reg("reset ctrl", ADDR_CTRL, 32'(0));
		check_reg("reset mask", ADDR_MASK, 32'hF);
		check_counters("reset");

		phase = "sideband";
		config_write(ADDR_CTRL, ctrl_word(1'b1, MODE_SIDEBAND));
		check_reg("ctrl readback", ADDR_CTRL, ctrl_word(1'b1, MODE_SIDEBAND));
		drive_words(N_SIDEBAND);
		drain();
		check_counters("sideband");

		// fresh mask for every burst, one burst fully masked
		phase = "round robin";
		config_write(ADDR_CTRL, ctrl_word(1'b1, MODE_ROUND_ROBIN));
		for (int b = 0; b < N_RR_BURSTS; b++)
		begin
			mask = (b == 3) ? '0 : NUM_NODE'($random(seed));
			config_write(ADDR_MASK, 32'(mask));
			drive_words(N_RR_BURST);
			drain();
		end

		phase = "partial mask";
		config_write(ADDR_CTRL, ctrl_word(1'b1, MODE_SIDEBAND));
		config_write(ADDR_MASK, 32'h6);
		drive_words(N_PARTIAL);
		config_write(ADDR_MASK, 32'h9);
		drive_words(N_PARTIAL);
		drain();
		check_reg("partial mask drop count", ADDR_DROP, 32'(m_drops));

		phase = "clear";
		check_counters("before clear");
		config_write(ADDR_CLEAR, 32'h1);
		check_counters("after clear");

		// disable lands while the stream still runs
		phase = "disable";
		config_write(ADDR_MASK, 32'hF);
		fork
			drive_words(N_DISABLE);
			begin
				repeat (25) @(negedge clk);
				config_write(ADDR_CTRL, ctrl_word(1'b0, MODE_SIDEBAND));
			end
		join
		compare("disable ready", 32'(1'b0), 32'(ready));
		drain();
		check_counters("disable");

		$display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
		if ((mismatch_errs == 0) && (other_errs == 0))
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/apb_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_ctrl (
	input  logic                          clk,
	input  logic                          i_rst,
	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [dist_pkg::ADDR_W-1:0]   i_paddr,
	input  logic [dist_pkg::APB_DW-1:0]   i_pwdata,
	output logic [dist_pkg::APB_DW-1:0]   o_prdata,
	input  logic [dist_pkg::CNT_W-1:0]    i_drop_cnt,
	dist_cfg_if.ctrl                      cfg
);
	import dist_pkg::*;

	// access phase qualifiers
	logic                wr_en;
	logic                rd_en;
	// counter window decode
	logic                cnt_hit;
	logic [ADDR_W-1:0]   cnt_offset;

	// register state
	logic                enable_q;
	logic                mode_q;
	logic [NUM_NODE-1:0] mask_q;
	logic                clear_q;

	// transfer completes when psel and penable are both high
	assign wr_en = i_psel && i_penable && i_pwrite;
	assign rd_en = i_psel && i_penable && !i_pwrite;

	////////////////////////////////////////
	// write decode
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			enable_q <= 1'b0;
			mode_q   <= MODE_SIDEBAND;
			mask_q   <= '1;
			clear_q  <= 1'b0;
		end
		else
		begin
			// pulse for one cycle after the clear write
			clear_q <= wr_en && (i_paddr == ADDR_CLEAR) && i_pwdata[0];
			if (wr_en && (i_paddr == ADDR_CTRL))
			begin
				enable_q <= i_pwdata[0];
				mode_q   <= i_pwdata[1];
			end
			if (wr_en && (i_paddr == ADDR_MASK))
				mask_q <= i_pwdata[NUM_NODE-1:0];
		end
	end

	assign cfg.enable = enable_q;
	assign cfg.mode   = mode_q;
	assign cfg.mask   = mask_q;
	assign cfg.clear  = clear_q;

	////////////////////////////////////////
	// read path
	////////////////////////////////////////

	// word aligned address inside the counter window
	assign cnt_hit    = (i_paddr >= ADDR_CNT_BASE) && (i_paddr <= ADDR_CNT_LAST)
		&& (i_paddr[1:0] == 2'b00);
	assign cnt_offset = i_paddr - ADDR_CNT_BASE;
	// counter index from the word offset
	assign cfg.cnt_sel = cnt_offset[2 +: NODE_W];

	always_comb
	begin
		o_prdata = '0;
		if (rd_en)
		begin
			if (cnt_hit)
				o_prdata = APB_DW'(cfg.cnt_value);
			else
			begin
				// clear register reads back as zero
				case (i_paddr)
					ADDR_CTRL: o_prdata = APB_DW'({mode_q, enable_q});
					ADDR_MASK: o_prdata = APB_DW'(mask_q);
					ADDR_DROP: o_prdata = APB_DW'(i_drop_cnt);
					default:   o_prdata = '0;
				endcase
			end
		end
	end

	// setup phase always sits between two access phases
	a_clear_single : assert property (@(posedge clk) disable iff (i_rst)
		cfg.clear |=> !cfg.clear);

endmodule

`default_nettype wire

/* logic/delivery_counters.sv */
`timescale 1ns/10ps
`default_nettype none

module delivery_counters (
	input  logic                            clk,
	input  logic                            i_rst,
	input  logic [dist_pkg::NUM_NODE-1:0]   i_node_valid,
	input  logic                            i_drop,
	output logic [dist_pkg::CNT_W-1:0]      o_drop_cnt,
	dist_cfg_if.stats                       cfg
);
	import dist_pkg::*;

	// one delivery count per node
	logic [CNT_W-1:0] node_cnt [NUM_NODE];
	logic [CNT_W-1:0] drop_cnt;

	////////////////////////////////////////
	// counting
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// clear beats a coinciding increment
		if (i_rst || cfg.clear)
		begin
			for (int k = 0; k < NUM_NODE; k++)
				node_cnt[k] <= '0;
			drop_cnt <= '0;
		end
		else
		begin
			// saturate at all ones
			for (int k = 0; k < NUM_NODE; k++)
			begin
				if (i_node_valid[k] && (node_cnt[k] != '1))
					node_cnt[k] <= node_cnt[k] + 1'b1;
			end
			if (i_drop && (drop_cnt != '1))
				drop_cnt <= drop_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// readback
	////////////////////////////////////////

	assign cfg.cnt_value = node_cnt[cfg.cnt_sel];
	assign o_drop_cnt    = drop_cnt;

endmodule

`default_nettype wire

/* logic/dest_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module dest_sequencer (
	input  logic                              clk,
	input  logic                              i_rst,
	input  logic                              i_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]   i_data,
	input  logic [dist_pkg::NODE_W-1:0]       i_dest,
	output logic                              o_ready,
	output logic                              o_word_valid,
	output logic [dist_pkg::DATA_WIDTH-1:0]   o_word_data,
	output logic [dist_pkg::NODE_W-1:0]       o_word_tag,
	output logic                              o_drop,
	dist_cfg_if.seq                           cfg
);
	import dist_pkg::*;

	logic              accept;
	// next node to try in round robin
	logic [NODE_W-1:0] rr_ptr;
	logic [NODE_W-1:0] rr_tag;
	logic [NODE_W-1:0] tag;
	logic              drop_now;

	// no downstream back pressure, enable alone gates input
	assign o_ready = cfg.enable;
	assign accept  = i_valid && o_ready;

	// first masked node at or after the pointer
	always_comb
	begin
		rr_tag = rr_ptr;
		// walk down so the closest hit wins
		for (int k = NUM_NODE - 1; k >= 0; k--)
		begin
			if (cfg.mask[(int'(rr_ptr) + k) % NUM_NODE])
				rr_tag = NODE_W'((int'(rr_ptr) + k) % NUM_NODE);
		end
	end

	// tag and drop by mode
	always_comb
	begin
		if (cfg.mode == MODE_ROUND_ROBIN)
		begin
			tag      = rr_tag;
			drop_now = (cfg.mask == '0);
		end
		else
		begin
			tag      = i_dest;
			drop_now = !cfg.mask[i_dest];
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			o_word_valid <= 1'b0;
			o_drop       <= 1'b0;
			rr_ptr       <= '0;
		end
		else
		begin
			o_word_valid <= accept && !drop_now;
			o_drop       <= accept && drop_now;
			// pointer moves past the node just served
			if (accept && !drop_now && (cfg.mode == MODE_ROUND_ROBIN))
				rr_ptr <= NODE_W'((int'(rr_tag) + 1) % NUM_NODE);
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		o_word_data <= i_data;
		o_word_tag  <= tag;
	end

	// issued tag was enabled in the mask seen at acceptance
	a_tag_masked : assert property (@(posedge clk) disable iff (i_rst)
		o_word_valid |-> |($past(cfg.mask) & (NUM_NODE'(1) << o_word_tag)));

endmodule

`default_nettype wire

/* logic/dist_cfg_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dist_cfg_if;
	import dist_pkg::*;

	// settings from the register file
	logic                enable;
	logic                mode;
	logic [NUM_NODE-1:0] mask;
	// one cycle pulse, zeroes the statistics
	logic                clear;

	// counter readback path
	logic [NODE_W-1:0]   cnt_sel;
	logic [CNT_W-1:0]    cnt_value;

	// register file side
	modport ctrl (
		output enable,
		output mode,
		output mask,
		output clear,
		output cnt_sel,
		input  cnt_value
	);

	// destination sequencer only needs the routing settings
	modport seq (input enable, input mode, input mask);

	modport stats (input clear, input cnt_sel, output cnt_value);

endinterface

`default_nettype wire

/* logic/dist_fabric_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dist_fabric_top (
	input  logic                                               clk,
	input  logic                                               i_rst,
	// apb slave
	input  logic                                               i_psel,
	input  logic                                               i_penable,
	input  logic                                               i_pwrite,
	input  logic [dist_pkg::ADDR_W-1:0]                        i_paddr,
	input  logic [dist_pkg::APB_DW-1:0]                        i_pwdata,
	output logic [dist_pkg::APB_DW-1:0]                        o_prdata,
	// word stream
	input  logic                                               i_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]                    i_data,
	input  logic [dist_pkg::NODE_W-1:0]                        i_dest,
	output logic                                               o_ready,
	// consumer nodes
	output logic [dist_pkg::NUM_NODE-1:0]                      o_node_valid,
	output logic [dist_pkg::NUM_NODE*dist_pkg::DATA_WIDTH-1:0] o_node_data
);
	import dist_pkg::*;

	// sequencer to chain
	logic                  word_valid;
	logic [DATA_WIDTH-1:0] word_data;
	logic [NODE_W-1:0]     word_tag;
	// statistics
	logic                  drop;
	logic [CNT_W-1:0]      drop_cnt;

	dist_cfg_if cfg ();

	apb_ctrl u_apb_ctrl (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_psel     (i_psel),
		.i_penable  (i_penable),
		.i_pwrite   (i_pwrite),
		.i_paddr    (i_paddr),
		.i_pwdata   (i_pwdata),
		.o_prdata   (o_prdata),
		.i_drop_cnt (drop_cnt),
		.cfg        (cfg.ctrl)
	);

	dest_sequencer u_dest_sequencer (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.i_dest       (i_dest),
		.o_ready      (o_ready),
		.o_word_valid (word_valid),
		.o_word_data  (word_data),
		.o_word_tag   (word_tag),
		.o_drop       (drop),
		.cfg          (cfg.seq)
	);

	unicast_chain u_unicast_chain (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_word_valid (word_valid),
		.i_word_data  (word_data),
		.i_word_tag   (word_tag),
		.o_node_valid (o_node_valid),
		.o_node_data  (o_node_data)
	);

	// counts what the nodes see at the top
	delivery_counters u_delivery_counters (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_node_valid (o_node_valid),
		.i_drop       (drop),
		.o_drop_cnt   (drop_cnt),
		.cfg          (cfg.stats)
	);

endmodule

`default_nettype wire

/* logic/dist_pkg.sv */
`default_nettype none

package dist_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////

	// consumer nodes on the chain
	localparam int NUM_NODE   = 4;
	localparam int DATA_WIDTH = 32;
	// destination tag, one node index
	localparam int NODE_W     = 2;
	// statistics counters saturate at this width
	localparam int CNT_W      = 16;
	localparam int ADDR_W     = 8;
	localparam int APB_DW     = 32;

	////////////////////////////////////////
	// register map
	////////////////////////////////////////

	// bit 0 enable, bit 1 mode
	localparam logic [ADDR_W-1:0] ADDR_CTRL     = 8'h00;
	localparam logic [ADDR_W-1:0] ADDR_MASK     = 8'h04;
	// write only, bit 0 fires the clear
	localparam logic [ADDR_W-1:0] ADDR_CLEAR    = 8'h08;
	localparam logic [ADDR_W-1:0] ADDR_DROP     = 8'h0C;
	// node n counter at base + 4n
	localparam logic [ADDR_W-1:0] ADDR_CNT_BASE = 8'h10;
	localparam logic [ADDR_W-1:0] ADDR_CNT_LAST = ADDR_CNT_BASE + ADDR_W'(4 * (NUM_NODE - 1));

	// destination mode encodings
	localparam logic MODE_SIDEBAND    = 1'b0;
	localparam logic MODE_ROUND_ROBIN = 1'b1;

endpackage

`default_nettype wire

/* logic/unicast_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module unicast_chain (
	input  logic                                            clk,
	input  logic                                            i_rst,
	input  logic                                            i_word_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]                 i_word_data,
	input  logic [dist_pkg::NODE_W-1:0]                     i_word_tag,
	output logic [dist_pkg::NUM_NODE-1:0]                   o_node_valid,
	output logic [dist_pkg::NUM_NODE*dist_pkg::DATA_WIDTH-1:0] o_node_data
);
	import dist_pkg::*;

	// stage n feeds node n
	// stage 0 is the sequencer word, the rest are hop registers
	logic                  stage_valid [NUM_NODE];
	logic [DATA_WIDTH-1:0] stage_data  [NUM_NODE];
	logic [NODE_W-1:0]     stage_tag   [NUM_NODE];

	assign stage_valid[0] = i_word_valid;
	assign stage_data[0]  = i_word_data;
	assign stage_tag[0]   = i_word_tag;

	genvar n;

	////////////////////////////////////////
	// hop registers
	////////////////////////////////////////

	generate
		for (n = 1; n < NUM_NODE; n++)
		begin : g_hop
			// word retires once it passes its own node
			always_ff @(posedge clk)
			begin
				if (i_rst)
					stage_valid[n] <= 1'b0;
				else
					stage_valid[n] <= stage_valid[n-1] && (stage_tag[n-1] != NODE_W'(n - 1));
			end

			// data and tag travel with valid
			always_ff @(posedge clk)
			begin
				stage_data[n] <= stage_data[n-1];
				stage_tag[n]  <= stage_tag[n-1];
			end
		end
	endgenerate

	////////////////////////////////////////
	// node outputs
	////////////////////////////////////////

	generate
		for (n = 0; n < NUM_NODE; n++)
		begin : g_node
			logic hit;

			// carried tag matches this node
			assign hit = stage_valid[n] && (stage_tag[n] == NODE_W'(n));

			always_ff @(posedge clk)
			begin
				if (i_rst)
				begin
					o_node_valid[n]                      <= 1'b0;
					o_node_data[n*DATA_WIDTH +: DATA_WIDTH] <= '0;
				end
				else if (hit)
				begin
					o_node_valid[n]                      <= 1'b1;
					o_node_data[n*DATA_WIDTH +: DATA_WIDTH] <= stage_data[n];
				end
				else
				begin
					// idle node shows zeros
					o_node_valid[n]                      <= 1'b0;
					o_node_data[n*DATA_WIDTH +: DATA_WIDTH] <= '0;
				end
			end

			a_idle_zero : assert property (@(posedge clk) disable iff (i_rst)
				!o_node_valid[n] |-> (o_node_data[n*DATA_WIDTH +: DATA_WIDTH] == '0));
		end
	endgenerate

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# build and run the fabric testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/10ps \
	--top-module tb_dist_fabric \
	-Mdir obj_dir \
	-f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_dist_fabric 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
